//--- source/trace_pkg.sv
// Assumes a five-stage in-order pipeline; cycle and sequence counters are 16 bits and wrap
package trace_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    // Sequence id and cycle counter widths
    localparam int SEQ_W   = 16;
    localparam int CYCLE_W = 16;

    // One event code per stage
    localparam int TAG_W   = 8;

    // Front-end stall counter, saturating
    localparam int STALL_W = 4;

    // Front table depth, larger than the five ids in flight
    localparam int LOG_DEPTH = 8;
    localparam int LOG_IDX_W = $clog2(LOG_DEPTH);

    //////////////////////////////////////////////////
    // Scalar types
    //////////////////////////////////////////////////

    typedef logic [SEQ_W-1:0]   seq_id_t;
    typedef logic [CYCLE_W-1:0] cycle_t;
    typedef logic [TAG_W-1:0]   event_tag_t;
    typedef logic [STALL_W-1:0] stall_cnt_t;

    // Stall count stops here
    localparam stall_cnt_t STALL_MAX = '1;

    //////////////////////////////////////////////////
    // Records
    //////////////////////////////////////////////////

    // Fetch and decode part of a record, 52 bits
    typedef struct packed {
        cycle_t     fetch_cycle;
        event_tag_t fetch_tag;
        cycle_t     decode_cycle;
        event_tag_t decode_tag;
        stall_cnt_t stall_cnt;
    } front_entry_t;

    // Execute and memory part of a record, 48 bits
    typedef struct packed {
        cycle_t     exec_cycle;
        event_tag_t exec_tag;
        cycle_t     mem_cycle;
        event_tag_t mem_tag;
    } back_entry_t;

    // Full retired-instruction record, 140 bits
    typedef struct packed {
        seq_id_t      seq_id;
        front_entry_t front;
        back_entry_t  back;
        cycle_t       wb_cycle;
        event_tag_t   wb_tag;
    } trace_rec_t;

    // Occupancy of one pipeline stage
    typedef struct packed {
        logic    valid;
        seq_id_t id;
    } stage_pos_t;

endpackage

//--- source/id_tracker.sv
// Flush squashes fetch, decode and the slot into execute; no new fetch on a flush or stall cycle
module id_tracker
    import trace_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       fetch_en,
    input  logic       stall,
    input  logic       flush,
    output stage_pos_t pos_f,
    output stage_pos_t pos_d,
    output stage_pos_t pos_e,
    output stage_pos_t pos_m,
    output stage_pos_t pos_w,
    output cycle_t     cycle
);

    // Id handed to the next fetched instruction
    seq_id_t next_id;

    // Front end moves this cycle
    logic front_adv;
    // New instruction is captured into fetch
    logic take_fetch;

    // Flush wins over stall
    assign front_adv  = !flush && !stall;
    assign take_fetch = front_adv && fetch_en;

    //////////////////////////////////////////////////
    // Counters
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            cycle   <= '0;
            next_id <= '0;
        end else begin
            // Free-running time base, wraps
            cycle <= cycle + 1'b1;
            // Ids only advance on an accepted fetch
            if (take_fetch) begin
                next_id <= next_id + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Front stages
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pos_f <= '0;
            pos_d <= '0;
        end else if (flush) begin
            // Squash both front slots, ids kept but dead
            pos_f.valid <= 1'b0;
            pos_d.valid <= 1'b0;
        end else if (front_adv) begin
            // Fetch slot shows the next id even when empty
            pos_f.valid <= fetch_en;
            pos_f.id    <= next_id;
            pos_d       <= pos_f;
        end
        // Stall falls through and holds both slots
    end

    //////////////////////////////////////////////////
    // Back stages
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pos_e <= '0;
            pos_m <= '0;
            pos_w <= '0;
        end else begin
            if (front_adv) begin
                pos_e <= pos_d;
            end else begin
                // Bubble on stall, squashed decode on flush
                pos_e.valid <= 1'b0;
            end
            // Memory and write-back never hold
            pos_m <= pos_e;
            pos_w <= pos_m;
        end
    end

endmodule

//--- source/front_log.sv
// Table holds one entry per low id bits; an entry is reused once its id is eight ids old
module front_log
    import trace_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stall,
    input  stage_pos_t           pos_f,
    input  stage_pos_t           pos_d,
    input  cycle_t               cycle,
    input  event_tag_t           fetch_tag,
    input  event_tag_t           decode_tag,
    input  logic [LOG_IDX_W-1:0] rd_idx,
    output front_entry_t         rd_entry
);

    // Per-instruction front data, indexed by id
    front_entry_t log_mem [LOG_DEPTH];

    // Stage occupancy one cycle back
    stage_pos_t prev_f;
    stage_pos_t prev_d;

    // First cycle of an instruction in the stage
    logic f_enter;
    logic d_enter;

    logic [LOG_IDX_W-1:0] f_idx;
    logic [LOG_IDX_W-1:0] d_idx;

    // Count up to STALL_MAX and stay there
    function automatic stall_cnt_t sat_inc(input stall_cnt_t v);
        return (v == STALL_MAX) ? v : v + 1'b1;
    endfunction

    //////////////////////////////////////////////////
    // Entry detection
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            prev_f <= '0;
            prev_d <= '0;
        end else begin
            prev_f <= pos_f;
            prev_d <= pos_d;
        end
    end

    // New id, or the slot was empty last cycle
    assign f_enter = pos_f.valid && (!prev_f.valid || (prev_f.id != pos_f.id));
    assign d_enter = pos_d.valid && (!prev_d.valid || (prev_d.id != pos_d.id));

    assign f_idx = pos_f.id[LOG_IDX_W-1:0];
    assign d_idx = pos_d.id[LOG_IDX_W-1:0];

    //////////////////////////////////////////////////
    // Table writes
    //////////////////////////////////////////////////

    // Fetch and decode ids always differ, so no write clash
    always_ff @(posedge clk) begin
        if (pos_f.valid) begin
            // Tag rewritten each cycle, last one sticks
            log_mem[f_idx].fetch_tag <= fetch_tag;
            if (f_enter) begin
                log_mem[f_idx].fetch_cycle <= cycle;
                // Fresh count for a new instruction
                log_mem[f_idx].stall_cnt   <= stall ? stall_cnt_t'(1) : '0;
            end else if (stall) begin
                log_mem[f_idx].stall_cnt <= sat_inc(log_mem[f_idx].stall_cnt);
            end
        end
        if (pos_d.valid) begin
            log_mem[d_idx].decode_tag <= decode_tag;
            if (d_enter) begin
                log_mem[d_idx].decode_cycle <= cycle;
            end
            // Keeps adding on top of the fetch count
            if (stall) begin
                log_mem[d_idx].stall_cnt <= sat_inc(log_mem[d_idx].stall_cnt);
            end
        end
    end

    // Combinational read for the assembler
    assign rd_entry = log_mem[rd_idx];

endmodule

//--- source/back_log.sv
// Execute and memory data follow the instruction one stage at a time; no hold, no stall
module back_log
    import trace_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  stage_pos_t  pos_e,
    input  stage_pos_t  pos_m,
    input  cycle_t      cycle,
    input  event_tag_t  exec_tag,
    input  event_tag_t  mem_tag,
    output back_entry_t wb_entry
);

    //////////////////////////////////////////////////
    // Memory-stage register
    //////////////////////////////////////////////////

    // Execute data of the instruction now in memory
    cycle_t     exec_cycle_m;
    event_tag_t exec_tag_m;

    always_ff @(posedge clk) begin
        if (rst) begin
            exec_cycle_m <= '0;
            exec_tag_m   <= '0;
        end else if (pos_e.valid) begin
            // Execute lasts one cycle, sample it here
            exec_cycle_m <= cycle;
            exec_tag_m   <= exec_tag;
        end
    end

    //////////////////////////////////////////////////
    // Write-back-stage register
    //////////////////////////////////////////////////

    // Memory slot is pos_e of the previous cycle,
    // so the data above belongs to pos_m here
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_entry <= '0;
        end else if (pos_m.valid) begin
            wb_entry.exec_cycle <= exec_cycle_m;
            wb_entry.exec_tag   <= exec_tag_m;
            // Memory data joins on the way into write-back
            wb_entry.mem_cycle  <= cycle;
            wb_entry.mem_tag    <= mem_tag;
        end
        // Bubbles leave the last entry in place
    end

endmodule

//--- source/trace_assembler.sv
// One record per retired instruction, one cycle after write-back; no back-pressure
module trace_assembler
    import trace_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  stage_pos_t           pos_w,
    input  cycle_t               cycle,
    input  event_tag_t           wb_tag,
    input  front_entry_t         front,
    input  back_entry_t          back,
    output logic [LOG_IDX_W-1:0] rd_idx,
    output logic                 trace_valid,
    output trace_rec_t           trace_rec
);

    //////////////////////////////////////////////////
    // Front table lookup
    //////////////////////////////////////////////////

    // Low id bits select the table entry
    assign rd_idx = pos_w.id[LOG_IDX_W-1:0];

    //////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////

    // Strobe follows write-back occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            trace_valid <= 1'b0;
        end else begin
            trace_valid <= pos_w.valid;
        end
    end

    // Record payload, only loaded on a real retire
    always_ff @(posedge clk) begin
        if (pos_w.valid) begin
            trace_rec.seq_id   <= pos_w.id;
            trace_rec.front    <= front;
            trace_rec.back     <= back;
            // Write-back is a single cycle
            trace_rec.wb_cycle <= cycle;
            trace_rec.wb_tag   <= wb_tag;
        end
    end

endmodule

//--- source/pipeline_trace.sv
// Trace unit top; record is a single-cycle pulse, squashed instructions give no record
module pipeline_trace
    import trace_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       fetch_en,
    input  logic       stall,
    input  logic       flush,
    input  event_tag_t fetch_tag,
    input  event_tag_t decode_tag,
    input  event_tag_t exec_tag,
    input  event_tag_t mem_tag,
    input  event_tag_t wb_tag,
    output logic       trace_valid,
    output trace_rec_t trace_rec
);

    // Stage occupancy and time base
    stage_pos_t pos_f;
    stage_pos_t pos_d;
    stage_pos_t pos_e;
    stage_pos_t pos_m;
    stage_pos_t pos_w;
    cycle_t     cycle;

    // Log results toward the assembler
    logic [LOG_IDX_W-1:0] rd_idx;
    front_entry_t         front_entry;
    back_entry_t          back_entry;

    //////////////////////////////////////////////////
    // Sequencing
    //////////////////////////////////////////////////

    id_tracker i_id_tracker (
        .clk      (clk),
        .rst      (rst),
        .fetch_en (fetch_en),
        .stall    (stall),
        .flush    (flush),
        .pos_f    (pos_f),
        .pos_d    (pos_d),
        .pos_e    (pos_e),
        .pos_m    (pos_m),
        .pos_w    (pos_w),
        .cycle    (cycle)
    );

    //////////////////////////////////////////////////
    // Logs and assembly
    //////////////////////////////////////////////////

    front_log i_front_log (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .pos_f      (pos_f),
        .pos_d      (pos_d),
        .cycle      (cycle),
        .fetch_tag  (fetch_tag),
        .decode_tag (decode_tag),
        .rd_idx     (rd_idx),
        .rd_entry   (front_entry)
    );

    back_log i_back_log (
        .clk      (clk),
        .rst      (rst),
        .pos_e    (pos_e),
        .pos_m    (pos_m),
        .cycle    (cycle),
        .exec_tag (exec_tag),
        .mem_tag  (mem_tag),
        .wb_entry (back_entry)
    );

    trace_assembler i_trace_assembler (
        .clk         (clk),
        .rst         (rst),
        .pos_w       (pos_w),
        .cycle       (cycle),
        .wb_tag      (wb_tag),
        .front       (front_entry),
        .back        (back_entry),
        .rd_idx      (rd_idx),
        .trace_valid (trace_valid),
        .trace_rec   (trace_rec)
    );

endmodule

//--- verification/trace_assert.sv
// Bound to the trace top; assumes fewer than 65536 records so record ids never wrap
module trace_assert
    import trace_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       stall,
    input logic       flush,
    input stage_pos_t pos_f,
    input logic       trace_valid,
    input trace_rec_t trace_rec
);

    // Id of the last record seen
    seq_id_t prev_id;
    logic    have_prev;

    // Number of property failures so far
    int n_fail = 0;

    always_ff @(posedge clk) begin
        if (rst) begin
            have_prev <= 1'b0;
            prev_id   <= '0;
        end else if (trace_valid) begin
            have_prev <= 1'b1;
            prev_id   <= trace_rec.seq_id;
        end
    end

    //////////////////////////////////////////////////
    // Properties
    //////////////////////////////////////////////////

    // No strobe out of a reset edge
    a_quiet_in_reset: assert property (@(posedge clk) rst |=> !trace_valid)
        else begin
            n_fail++;
            $error("trace_valid high after a reset edge");
        end

    // Fetch slot frozen by a plain stall
    a_fetch_hold: assert property (@(posedge clk) disable iff (rst)
        (stall && !flush) |=> $stable(pos_f))
        else begin
            n_fail++;
            $error("pos_f changed during a stall");
        end

    // Records leave in rising id order
    a_ids_rise: assert property (@(posedge clk) disable iff (rst)
        (trace_valid && have_prev) |-> (trace_rec.seq_id > prev_id))
        else begin
            n_fail++;
            $error("record id not above the previous one");
        end

endmodule

bind pipeline_trace trace_assert i_trace_assert (
    .clk         (clk),
    .rst         (rst),
    .stall       (stall),
    .flush       (flush),
    .pos_f       (pos_f),
    .trace_valid (trace_valid),
    .trace_rec   (trace_rec)
);

//--- verification/tb_pipeline_trace.sv
// Random run from seed 83; model records are kept by the low 10 id bits, under 1024 fetches
module tb_pipeline_trace;
    import trace_pkg::*;

    localparam int RESET_CYCLES = 4;
    localparam int PHASE_CYCLES = 150;
    localparam int IDLE_CYCLES  = 20;
    // Reset, four phases of 150, the drain and some margin
    localparam int TIMEOUT_CYCLES = 700;

    logic       clk = 1'b0;
    logic       rst;
    logic       fetch_en;
    logic       stall;
    logic       flush;
    event_tag_t fetch_tag;
    event_tag_t decode_tag;
    event_tag_t exec_tag;
    event_tag_t mem_tag;
    event_tag_t wb_tag;
    logic       trace_valid;
    trace_rec_t trace_rec;

    //////////////////////////////////////////////////
    // Reference model state
    //////////////////////////////////////////////////

    // Index 0 is fetch, 4 is write-back
    stage_pos_t m_pos [5];
    // Stage was loaded by the last edge
    logic       fresh_f;
    logic       fresh_d;
    seq_id_t    m_next_id;
    cycle_t     m_cycle;
    // Record under construction, per id
    trace_rec_t m_rec [1024];
    logic       squashed [1024];
    logic       m_retired;
    trace_rec_t exp_q [$];

    int      n_checks;
    int      n_errors;
    int      t_checks;
    int      t_errors;
    int      n_records;
    int      m_count;
    int      phase;
    int      cyc_count;
    seq_id_t last_id;

    pipeline_trace i_dut (.*);

    always #5 clk = ~clk;

    // Hard stop if the run overruns
    always @(posedge clk) begin
        cyc_count++;
        if (cyc_count > TIMEOUT_CYCLES) begin
            $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic count_checks(input int n);
        n_checks += n;
        t_checks += n;
    endtask

    task automatic report_value(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        $display("[FAIL] %0t %s: got 'h%0h expected 'h%0h", $time, name, got, exp);
        n_errors++;
        t_errors++;
    endtask

    task automatic report_text(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        n_errors++;
        t_errors++;
    endtask

    // One stall cycle more, stuck at 15
    function automatic stall_cnt_t add_stall(input stall_cnt_t cnt, input logic s);
        int total;
        total = int'(cnt) + int'(s);
        return (total > 15) ? stall_cnt_t'(15) : stall_cnt_t'(total);
    endfunction

    // Every stage entered one cycle after the one before, no stall cycles
    function automatic logic clean_flow(input trace_rec_t r);
        return r.front.stall_cnt == 0
            && cycle_t'(r.front.decode_cycle - r.front.fetch_cycle) == 1
            && cycle_t'(r.back.exec_cycle - r.front.decode_cycle) == 1
            && cycle_t'(r.back.mem_cycle - r.back.exec_cycle) == 1
            && cycle_t'(r.wb_cycle - r.back.mem_cycle) == 1;
    endfunction

    //////////////////////////////////////////////////
    // Model of one clock edge
    //////////////////////////////////////////////////

    // Uses the state and the inputs of the cycle before the edge
    task automatic model_edge();
        logic [9:0] fi;
        logic [9:0] di;
        logic [9:0] wi;
        logic       adv;
        fi  = m_pos[0].id[9:0];
        di  = m_pos[1].id[9:0];
        wi  = m_pos[4].id[9:0];
        adv = !flush && !stall;
        // Entry cycle once, tag every cycle so the last one stays
        if (m_pos[0].valid) begin
            if (fresh_f) begin
                m_rec[fi].front.fetch_cycle = m_cycle;
                m_rec[fi].front.stall_cnt   = '0;
            end
            m_rec[fi].front.fetch_tag = fetch_tag;
            m_rec[fi].front.stall_cnt = add_stall(m_rec[fi].front.stall_cnt, stall);
        end
        if (m_pos[1].valid) begin
            if (fresh_d)
                m_rec[di].front.decode_cycle = m_cycle;
            m_rec[di].front.decode_tag = decode_tag;
            m_rec[di].front.stall_cnt  = add_stall(m_rec[di].front.stall_cnt, stall);
        end
        // Back stages last a single cycle each
        if (m_pos[2].valid) begin
            m_rec[m_pos[2].id[9:0]].back.exec_cycle = m_cycle;
            m_rec[m_pos[2].id[9:0]].back.exec_tag   = exec_tag;
        end
        if (m_pos[3].valid) begin
            m_rec[m_pos[3].id[9:0]].back.mem_cycle = m_cycle;
            m_rec[m_pos[3].id[9:0]].back.mem_tag   = mem_tag;
        end
        if (m_pos[4].valid) begin
            m_rec[wi].seq_id   = m_pos[4].id;
            m_rec[wi].wb_cycle = m_cycle;
            m_rec[wi].wb_tag   = wb_tag;
            exp_q.push_back(m_rec[wi]);
            m_retired = 1'b1;
            m_count++;
        end
        // Back end never holds, execute takes a bubble unless the front moves
        m_pos[4] = m_pos[3];
        m_pos[3] = m_pos[2];
        m_pos[2] = adv ? m_pos[1] : '0;
        fresh_f  = 1'b0;
        fresh_d  = 1'b0;
        if (flush) begin
            if (m_pos[0].valid)
                squashed[fi] = 1'b1;
            if (m_pos[1].valid)
                squashed[di] = 1'b1;
            m_pos[0].valid = 1'b0;
            m_pos[1].valid = 1'b0;
        end else if (adv) begin
            m_pos[1]       = m_pos[0];
            fresh_d        = m_pos[0].valid;
            m_pos[0].valid = fetch_en;
            m_pos[0].id    = m_next_id;
            fresh_f        = fetch_en;
            if (fetch_en)
                m_next_id++;
        end
        m_cycle++;
    endtask

    //////////////////////////////////////////////////
    // Output checks and stimulus
    //////////////////////////////////////////////////

    task automatic check_outputs();
        trace_rec_t exp;
        count_checks(1);
        if (trace_valid !== m_retired)
            report_value("trace_valid", 64'(trace_valid), 64'(m_retired));
        // Every pulse counts, matched or not
        if (trace_valid === 1'b1)
            n_records++;
        if (trace_valid === 1'b1 && exp_q.size() == 0)
            report_text("record came out while the model retired nothing");
        if (trace_valid === 1'b1 && exp_q.size() != 0) begin
            exp = exp_q.pop_front();
            count_checks(7);
            if (trace_rec.seq_id !== exp.seq_id)
                report_value("trace_rec.seq_id", 64'(trace_rec.seq_id), 64'(exp.seq_id));
            if (trace_rec.front !== exp.front)
                report_value("trace_rec.front", 64'(trace_rec.front), 64'(exp.front));
            if (trace_rec.back !== exp.back)
                report_value("trace_rec.back", 64'(trace_rec.back), 64'(exp.back));
            if (trace_rec.wb_cycle !== exp.wb_cycle)
                report_value("trace_rec.wb_cycle", 64'(trace_rec.wb_cycle), 64'(exp.wb_cycle));
            if (trace_rec.wb_tag !== exp.wb_tag)
                report_value("trace_rec.wb_tag", 64'(trace_rec.wb_tag), 64'(exp.wb_tag));
            if (squashed[trace_rec.seq_id[9:0]])
                report_text($sformatf("squashed id %0d produced a record", trace_rec.seq_id));
            if (n_records > 1 && trace_rec.seq_id <= last_id)
                report_text($sformatf("id %0d follows id %0d", trace_rec.seq_id, last_id));
            last_id = trace_rec.seq_id;
            if (phase == 1) begin
                count_checks(1);
                if (!clean_flow(trace_rec))
                    report_text("unstalled record has a stage gap or stall cycles");
            end
        end
    endtask

    // Edge just passed is modeled, then new inputs for the next one
    task automatic run_cycle(input int fetch_pct, input int stall_pct, input int flush_pct);
        @(negedge clk);
        m_retired = 1'b0;
        if (!rst)
            model_edge();
        check_outputs();
        fetch_en   = ($urandom % 100) < fetch_pct;
        stall      = ($urandom % 100) < stall_pct;
        flush      = ($urandom % 100) < flush_pct;
        fetch_tag  = event_tag_t'($urandom);
        decode_tag = event_tag_t'($urandom);
        exec_tag   = event_tag_t'($urandom);
        mem_tag    = event_tag_t'($urandom);
        wb_tag     = event_tag_t'($urandom);
    endtask

    task automatic run_phase(input int id, input int cycles, input int fetch_pct,
                             input int stall_pct, input int flush_pct);
        phase    = id;
        t_checks = 0;
        t_errors = 0;
        repeat (cycles) run_cycle(fetch_pct, stall_pct, flush_pct);
    endtask

    task automatic print_test(input string name);
        $display("test %-16s %0d checks, %0d errors", name, t_checks, t_errors);
    endtask

    initial begin
        void'($urandom(83));
        rst        = 1'b1;
        fetch_en   = 1'b0;
        stall      = 1'b0;
        flush      = 1'b0;
        fetch_tag  = '0;
        decode_tag = '0;
        exec_tag   = '0;
        mem_tag    = '0;
        wb_tag     = '0;
        foreach (m_pos[i])
            m_pos[i] = '0;
        foreach (squashed[i])
            squashed[i] = 1'b0;
        fresh_f   = 1'b0;
        fresh_d   = 1'b0;
        m_next_id = '0;
        m_cycle   = '0;
        run_phase(0, RESET_CYCLES, 0, 0, 0);
        rst = 1'b0;
        print_test("reset");
        run_phase(1, PHASE_CYCLES, 80, 0, 0);
        print_test("unstalled flow");
        run_phase(2, PHASE_CYCLES, 80, 25, 0);
        print_test("stall");
        run_phase(3, PHASE_CYCLES, 80, 0, 8);
        print_test("flush");
        run_phase(4, PHASE_CYCLES, 80, 25, 8);
        print_test("random and tags");
        run_phase(5, IDLE_CYCLES, 0, 0, 0);
        count_checks(3);
        if (exp_q.size() != 0)
            report_text($sformatf("%0d expected records never came out", exp_q.size()));
        if (n_records != m_count)
            report_text($sformatf("%0d records seen, model retired %0d", n_records, m_count));
        // Bound checker keeps its own failure count
        if (i_dut.i_trace_assert.n_fail != 0)
            report_text($sformatf("%0d assertion failures in the bound checker",
                                  i_dut.i_trace_assert.n_fail));
        print_test("completeness");
        $display("summary: %0d checks, %0d errors, %0d records", n_checks, n_errors, n_records);
        if (n_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
source/trace_pkg.sv
source/id_tracker.sv
source/front_log.sv
source/back_log.sv
source/trace_assembler.sv
source/pipeline_trace.sv
verification/trace_assert.sv
verification/tb_pipeline_trace.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass line
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_pipeline_trace -f verilog.f \
        --Mdir obj_dir -o sim_pipeline_trace; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_pipeline_trace > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^ALL CHECKS PASSED$" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1
